//--- src/vcr_pkg.sv
// router package
// sizes of the router slice and the flit format shared by all blocks
`default_nettype none

package vcr_pkg;

  // port counts
  localparam int NUM_IN  = 2;
  localparam int NUM_OUT = 3;

  // virtual channels per input port
  localparam int NUM_VC = 4;
  localparam int VC_W   = 2;

  // width of a port index, used for input and output indices alike
  localparam int PORT_W = 2;

  // flit slots in each input VC queue, a power of two
  localparam int VC_DEPTH = 4;

  // downstream buffer slots per output
  localparam int OUT_CREDITS = 4;
  localparam int CREDIT_W    = 3;

  localparam int PAYLOAD_W = 16;

  // header is read on every flit, so it rides along with the payload
  typedef struct packed {
    // set on the tail flit of a packet
    logic                 last;
    // lookahead output port index
    logic [PORT_W-1:0]    dest;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

//--- src/sa_req_if.sv
// switch request interface
// one input port's chosen head flit going to switch allocation, with its grant
`timescale 1ns/1ps
`default_nettype none

interface sa_req_if import vcr_pkg::*; ();

  // any VC head of this input is valid
  logic               req;
  // VC the head was taken from
  logic [VC_W-1:0]    vc_id;
  // requested output, all zero without a request
  logic [NUM_OUT-1:0] dir_oh;
  flit_t              flit;
  // flit accepted this cycle
  logic               gnt;

  modport initiator (output req, output vc_id, output dir_oh, output flit, input gnt);
  modport target    (input req, input vc_id, input dir_oh, input flit, output gnt);

endinterface

`default_nettype wire

//--- src/vc_buffer.sv
// input VC buffer
// one circular flit queue per VC, head outputs and a credit pulse per pop
`timescale 1ns/1ps
`default_nettype none

module vc_buffer import vcr_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  wr_valid_i,
  input  logic [VC_W-1:0]       wr_vc_i,
  input  flit_t                 wr_flit_i,
  input  logic [NUM_VC-1:0]     pop_oh_i,
  output logic [NUM_VC-1:0]     head_v_o,
  output flit_t [NUM_VC-1:0]    head_o,
  output logic                  credit_o,
  output logic [VC_W-1:0]       credit_vc_o
);

  // pops that actually take a flit
  logic [NUM_VC-1:0] pop_v;
  logic              pop_any;
  logic [VC_W-1:0]   pop_id;

  for (genvar v = 0; v < NUM_VC; v++) begin : g_vc
    flit_t                        mem_q [VC_DEPTH];
    logic [$clog2(VC_DEPTH)-1:0]  wr_ptr_q;
    logic [$clog2(VC_DEPTH)-1:0]  rd_ptr_q;
    // occupancy, fits the same range as a credit count
    logic [CREDIT_W-1:0]          cnt_q;
    logic                         push;

    // sender keeps track of credits, a write to a full queue is its fault
    assign push     = wr_valid_i && (wr_vc_i == VC_W'(v));
    assign pop_v[v] = pop_oh_i[v] && head_v_o[v];

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= wr_flit_i;
      end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (pop_v[v]) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
        case ({push, pop_v[v]})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    // oldest flit is the head, valid one cycle after its write
    assign head_v_o[v] = (cnt_q != '0);
    assign head_o[v]   = mem_q[rd_ptr_q];
  end

  // at most one pop per cycle, encode its VC
  always_comb begin
    pop_any = 1'b0;
    pop_id  = '0;
    for (int v = 0; v < NUM_VC; v++) begin
      if (pop_v[v]) begin
        pop_any = 1'b1;
        pop_id  = VC_W'(v);
      end
    end
  end

  // freed slot goes back upstream one cycle after the pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_o    <= 1'b0;
      credit_vc_o <= '0;
    end else begin
      credit_o    <= pop_any;
      credit_vc_o <= pop_id;
    end
  end

endmodule

`default_nettype wire

//--- src/sa_local.sv
// local switch allocator
// round-robin pick of one valid VC head per input, with wormhole pointer hold
`timescale 1ns/1ps
`default_nettype none

module sa_local import vcr_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NUM_VC-1:0]   head_v_i,
  input  flit_t [NUM_VC-1:0]  head_i,
  output logic [NUM_VC-1:0]   pop_oh_o,
  sa_req_if.initiator         req
);

  // priority pointer, this VC is looked at first
  logic [VC_W-1:0]   ptr_q;
  logic              found;
  logic [VC_W-1:0]   sel_id;
  logic [VC_W-1:0]   nxt_id;
  logic [NUM_VC-1:0] sel_oh;
  flit_t             sel_flit;

  // two passes: from the pointer up, then wrap to the bottom
  always_comb begin
    found  = 1'b0;
    sel_id = '0;
    for (int i = 0; i < NUM_VC; i++) begin
      if (!found && head_v_i[i] && (i >= int'(ptr_q))) begin
        found  = 1'b1;
        sel_id = VC_W'(i);
      end
    end
    for (int i = 0; i < NUM_VC; i++) begin
      if (!found && head_v_i[i]) begin
        found  = 1'b1;
        sel_id = VC_W'(i);
      end
    end
  end

  always_comb begin
    sel_oh = '0;
    sel_oh[sel_id] = found;
  end

  assign sel_flit = head_i[sel_id];
  assign nxt_id   = (sel_id == VC_W'(NUM_VC - 1)) ? '0 : sel_id + 1'b1;

  // request towards switch allocation
  assign req.req   = found;
  assign req.vc_id = sel_id;
  assign req.flit  = sel_flit;

  // lookahead dest turned into a one-hot direction
  always_comb begin
    for (int o = 0; o < NUM_OUT; o++) begin
      req.dir_oh[o] = found && (sel_flit.dest == PORT_W'(o));
    end
  end

  // only a granted flit leaves its queue
  assign pop_oh_o = req.gnt ? sel_oh : '0;

  // granted body flit keeps the packet's VC on top
  // tail flit or a blocked head hands the turn to the next VC
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (found) begin
      if (req.gnt && !sel_flit.last) begin
        ptr_q <= sel_id;
      end else begin
        ptr_q <= nxt_id;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/switch_alloc_fsm.sv
// switch allocator
// per-output IDLE/LOCKED state, input round robin and the registered output flit
`timescale 1ns/1ps
`default_nettype none

module switch_alloc_fsm import vcr_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  sa_req_if.target             req [NUM_IN],
  input  logic [NUM_OUT-1:0]   has_credit_i,
  output logic [NUM_OUT-1:0]   send_oh_o,
  output logic [NUM_OUT-1:0]   out_valid_o,
  output flit_t [NUM_OUT-1:0]  out_flit_o
);

  // requests unpacked from the interfaces
  logic [NUM_IN-1:0]                in_req;
  logic [NUM_IN-1:0][NUM_OUT-1:0]   in_dir;
  logic [NUM_IN-1:0][VC_W-1:0]      in_vc;
  flit_t [NUM_IN-1:0]               in_flit;
  // grant of each output towards each input
  logic [NUM_OUT-1:0][NUM_IN-1:0]   out_gnt;
  // grant seen by each input
  logic [NUM_IN-1:0]                in_gnt;

  // an input asks for one output at a time, so OR is enough
  always_comb begin
    in_gnt = '0;
    for (int o = 0; o < NUM_OUT; o++) begin
      in_gnt = in_gnt | out_gnt[o];
    end
  end

  for (genvar i = 0; i < NUM_IN; i++) begin : g_in
    assign in_req[i]  = req[i].req;
    assign in_dir[i]  = req[i].dir_oh;
    assign in_vc[i]   = req[i].vc_id;
    assign in_flit[i] = req[i].flit;
    assign req[i].gnt = in_gnt[i];
  end

  for (genvar o = 0; o < NUM_OUT; o++) begin : g_out
    // high in LOCKED and low in IDLE
    logic              locked_q;
    logic [PORT_W-1:0] lock_in_q;
    logic [VC_W-1:0]   lock_vc_q;
    logic [PORT_W-1:0] rr_q;
    logic [NUM_IN-1:0] cand;
    logic              win_v;
    logic [PORT_W-1:0] win_id;
    logic [VC_W-1:0]   win_vc;
    flit_t             win_flit;
    logic [PORT_W-1:0] rr_nxt;
    logic              valid_q;
    flit_t             flit_q;

    // when locked only the owning (input, vc) may compete
    always_comb begin
      for (int i = 0; i < NUM_IN; i++) begin
        cand[i] = in_req[i] && in_dir[i][o] &&
                  (!locked_q || ((lock_in_q == PORT_W'(i)) && (lock_vc_q == in_vc[i])));
      end
    end

    // round robin from rr_q and no grant without a credit
    always_comb begin
      win_v    = 1'b0;
      win_id   = '0;
      win_vc   = '0;
      win_flit = '0;
      for (int i = 0; i < NUM_IN; i++) begin
        if (!win_v && cand[i] && (i >= int'(rr_q))) begin
          win_v    = 1'b1;
          win_id   = PORT_W'(i);
          win_vc   = in_vc[i];
          win_flit = in_flit[i];
        end
      end
      for (int i = 0; i < NUM_IN; i++) begin
        if (!win_v && cand[i]) begin
          win_v    = 1'b1;
          win_id   = PORT_W'(i);
          win_vc   = in_vc[i];
          win_flit = in_flit[i];
        end
      end
      win_v = win_v && has_credit_i[o];
    end

    // one-hot grant towards the winning input
    assign out_gnt[o] = win_v ? (NUM_IN'(1) << win_id) : '0;

    assign rr_nxt = (win_id == PORT_W'(NUM_IN - 1)) ? '0 : win_id + 1'b1;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        locked_q  <= 1'b0;
        lock_in_q <= '0;
        lock_vc_q <= '0;
        rr_q      <= '0;
        valid_q   <= 1'b0;
      end else begin
        valid_q <= win_v;
        if (win_v) begin
          if (locked_q) begin
            // tail releases the output
            if (win_flit.last) begin
              locked_q <= 1'b0;
            end
          end else if (!win_flit.last) begin
            // head of a multi-flit packet claims the output
            locked_q  <= 1'b1;
            lock_in_q <= win_id;
            lock_vc_q <= win_vc;
          end
          // inputs take turns per packet
          if (win_flit.last) begin
            rr_q <= rr_nxt;
          end
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (win_v) begin
        flit_q <= win_flit;
      end
    end

    assign send_oh_o[o]   = win_v;
    assign out_valid_o[o] = valid_q;
    assign out_flit_o[o]  = flit_q;
  end

endmodule

`default_nettype wire

//--- src/credit_counter.sv
// downstream credit counters
// free slot count per output, has_credit blocks grants at zero
`timescale 1ns/1ps
`default_nettype none

module credit_counter import vcr_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [NUM_OUT-1:0] send_oh_i,
  input  logic [NUM_OUT-1:0] credit_i,
  output logic [NUM_OUT-1:0] has_credit_o
);

  for (genvar o = 0; o < NUM_OUT; o++) begin : g_cnt
    logic [CREDIT_W-1:0] cnt_q;

    // send and return in one cycle cancel out
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q <= CREDIT_W'(OUT_CREDITS);
      end else begin
        case ({send_oh_i[o], credit_i[o]})
          2'b10:   cnt_q <= cnt_q - 1'b1;
          2'b01:   cnt_q <= cnt_q + 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    // a send is only granted with a nonzero count, so no underflow
    assign has_credit_o[o] = (cnt_q != '0);
  end

endmodule

`default_nettype wire

//--- src/vc_router.sv
// wormhole VC router slice, two inputs and three outputs
// input VC buffers, local and switch allocation, downstream credit counting
`timescale 1ns/1ps
`default_nettype none

module vc_router import vcr_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // input ports
  input  logic [NUM_IN-1:0]            in_valid_i,
  input  logic [NUM_IN-1:0][VC_W-1:0]  in_vc_i,
  input  flit_t [NUM_IN-1:0]           in_flit_i,
  output logic [NUM_IN-1:0]            in_credit_o,
  output logic [NUM_IN-1:0][VC_W-1:0]  in_credit_vc_o,
  // output ports
  output logic [NUM_OUT-1:0]           out_valid_o,
  output flit_t [NUM_OUT-1:0]          out_flit_o,
  input  logic [NUM_OUT-1:0]           out_credit_i
);

  // buffer heads per input and VC
  logic [NUM_IN-1:0][NUM_VC-1:0]  head_v;
  flit_t [NUM_IN-1:0][NUM_VC-1:0] head;
  logic [NUM_IN-1:0][NUM_VC-1:0]  pop_oh;
  // allocator to counter handshake
  logic [NUM_OUT-1:0]             send_oh;
  logic [NUM_OUT-1:0]             has_credit;

  sa_req_if sa_req [NUM_IN] ();

  for (genvar i = 0; i < NUM_IN; i++) begin : g_port
    vc_buffer u_vc_buffer (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .wr_valid_i  (in_valid_i[i]),
      .wr_vc_i     (in_vc_i[i]),
      .wr_flit_i   (in_flit_i[i]),
      .pop_oh_i    (pop_oh[i]),
      .head_v_o    (head_v[i]),
      .head_o      (head[i]),
      .credit_o    (in_credit_o[i]),
      .credit_vc_o (in_credit_vc_o[i])
    );

    sa_local u_sa_local (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .head_v_i (head_v[i]),
      .head_i   (head[i]),
      .pop_oh_o (pop_oh[i]),
      .req      (sa_req[i])
    );
  end

  // output side allocation and flit registers
  switch_alloc_fsm u_switch_alloc_fsm (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req          (sa_req),
    .has_credit_i (has_credit),
    .send_oh_o    (send_oh),
    .out_valid_o  (out_valid_o),
    .out_flit_o   (out_flit_o)
  );

  credit_counter u_credit_counter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .send_oh_i    (send_oh),
    .credit_i     (out_credit_i),
    .has_credit_o (has_credit)
  );

endmodule

`default_nettype wire

//--- tb/tb_vc_router.sv
// testbench for the VC router slice
// random wormhole traffic with sender and downstream credit models and a scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_vc_router import vcr_pkg::*; ();

  localparam int FAIR_PKTS = 8;
  localparam int RAND_PKTS = 40;
  // worst case flit count of all phases sets the cycle limit
  localparam int MAX_FLITS = 1 + NUM_IN * FAIR_PKTS + NUM_IN * RAND_PKTS * 4;
  localparam int LIMIT     = MAX_FLITS * 20 + 200;

  logic                        clk_i;
  logic                        rst_n_i;
  logic [NUM_IN-1:0]           in_valid_i;
  logic [NUM_IN-1:0][VC_W-1:0] in_vc_i;
  flit_t [NUM_IN-1:0]          in_flit_i;
  logic [NUM_IN-1:0]           in_credit_o;
  logic [NUM_IN-1:0][VC_W-1:0] in_credit_vc_o;
  logic [NUM_OUT-1:0]          out_valid_o;
  flit_t [NUM_OUT-1:0]         out_flit_o;
  logic [NUM_OUT-1:0]          out_credit_i = '0;

  integer seed = 32'h1ce9;
  int     cycle = 0;
  int     err_val = 0;
  int     err_misc = 0;
  int     tx_cnt = 0;
  int     rx_cnt = 0;
  int     seq = 0;
  // expected flits per (input, VC), index is input*NUM_VC+vc
  flit_t  exp_q [NUM_IN*NUM_VC][$];
  // free slots per input VC as the sender sees them
  int     vc_cred [NUM_IN][NUM_VC];
  // flits still to send of the open packet per VC, and its dest
  int     rem [NUM_IN][NUM_VC];
  int     dst [NUM_IN][NUM_VC];
  int     pkts_left [NUM_IN];
  // flits held downstream per output, not yet credited back
  int     pending [NUM_OUT];
  // packet that owns each output, -1 between packets
  int     owner [NUM_OUT];
  logic [NUM_OUT-1:0] ret_mask = '0;
  logic   withhold = 1'b0;
  logic   fair_on = 1'b0;
  int     fair_seen = 0;
  int     fair_cnt [NUM_IN];

  vc_router vc_router_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_vc_i        (in_vc_i),
    .in_flit_i      (in_flit_i),
    .in_credit_o    (in_credit_o),
    .in_credit_vc_o (in_credit_vc_o),
    .out_valid_o    (out_valid_o),
    .out_flit_o     (out_flit_o),
    .out_credit_i   (out_credit_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // cycle count and run limit
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d flits received", cycle, rx_cnt, tx_cnt);
      $display("errors: %0d value, %0d other", err_val, err_misc);
      $display("TEST FAILED");
      $finish;
    end
  end

  // downstream credit pulses, decided at the falling edge before
  always @(posedge clk_i) begin
    out_credit_i <= ret_mask;
  end

  // output port a flit has to leave on, from its lookahead header
  function automatic int ref_port(flit_t f);
    return int'(f.dest);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_val++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycle);
    end
  endtask

  task automatic note_failure(input string msg);
    err_misc++;
    $display("error at cycle %0d: %s", cycle, msg);
  endtask

  // source input and VC ride in the payload so the scoreboard finds the queue
  function automatic flit_t make_flit(int i, int vc, int dest, bit last, int n);
    flit_t f;
    f.last    = last;
    f.dest    = PORT_W'(dest);
    f.payload = {1'(i), VC_W'(vc), 13'(n)};
    return f;
  endfunction

  // called right after a rising edge
  task automatic send_flit(input int i, input int vc, input int dest, input bit last);
    flit_t f;
    f = make_flit(i, vc, dest, last, seq);
    seq++;
    exp_q[i*NUM_VC+vc].push_back(f);
    vc_cred[i][vc]--;
    tx_cnt++;
    in_valid_i[i] <= 1'b1;
    in_vc_i[i]    <= VC_W'(vc);
    in_flit_i[i]  <= f;
  endtask

  // random start, first VC with a free slot, open packets only if asked
  task automatic pick_vc(input int i, input bit open_only, output int vc);
    int start;
    int c;
    start = ($random(seed) & 32'h7fff) % NUM_VC;
    vc = -1;
    for (int k = 0; k < NUM_VC; k++) begin
      c = (start + k) % NUM_VC;
      if (vc < 0 && vc_cred[i][c] > 0 && (rem[i][c] > 0 || !open_only)) begin
        vc = c;
      end
    end
  endtask

  // one input, one cycle of random packet traffic
  task automatic random_step(input int i);
    int vc;
    if (($random(seed) & 3) != 0) begin
      pick_vc(i, pkts_left[i] == 0, vc);
      if (vc >= 0) begin
        if (rem[i][vc] == 0) begin
          rem[i][vc] = 1 + ($random(seed) & 3);
          dst[i][vc] = ($random(seed) & 32'h7fff) % NUM_OUT;
          pkts_left[i]--;
        end
        rem[i][vc]--;
        send_flit(i, vc, dst[i][vc], rem[i][vc] == 0);
      end
    end
  endtask

  // every flit out, every credit back on both sides
  function automatic bit drained();
    bit d;
    d = (rx_cnt == tx_cnt);
    for (int o = 0; o < NUM_OUT; o++) begin
      if (pending[o] != 0) d = 1'b0;
    end
    for (int i = 0; i < NUM_IN; i++) begin
      for (int v = 0; v < NUM_VC; v++) begin
        if (vc_cred[i][v] != VC_DEPTH) d = 1'b0;
      end
    end
    return d;
  endfunction

  task automatic wait_drain();
    @(posedge clk_i);
    in_valid_i <= '0;
    while (!drained()) @(posedge clk_i);
  endtask

  // scoreboard, sampled at the falling edge where outputs are stable
  always @(negedge clk_i) begin
    flit_t                       f;
    flit_t                       e;
    int                          s;
    int                          src_in;
    logic [NUM_IN-1:0]           cred_exp;
    logic [NUM_IN-1:0][VC_W-1:0] cred_vc;
    if (rst_n_i) begin
      cred_exp = '0;
      cred_vc  = '0;
      for (int o = 0; o < NUM_OUT; o++) begin
        if (out_valid_o[o]) begin
          f      = out_flit_o[o];
          src_in = int'(f.payload[15]);
          s      = src_in * NUM_VC + int'(f.payload[14:13]);
          rx_cnt++;
          if (exp_q[s].size() == 0) begin
            note_failure($sformatf("output %0d shows a flit that was never sent", o));
          end else begin
            e = exp_q[s].pop_front();
            check_val($sformatf("out_flit_o[%0d]", o), 32'(f), 32'(e));
            check_val($sformatf("out_flit_o[%0d] port", o), 32'(o), 32'(ref_port(e)));
          end
          // wormhole, a started packet keeps the output to itself
          if (owner[o] >= 0 && owner[o] != s) begin
            note_failure($sformatf("output %0d interleaves two packets", o));
          end
          owner[o] = f.last ? -1 : s;
          pending[o]++;
          if (pending[o] > OUT_CREDITS) begin
            note_failure($sformatf("output %0d sent more flits than it had credits", o));
          end
          // the pop behind this flit returns its credit in the same cycle
          cred_exp[src_in] = 1'b1;
          cred_vc[src_in]  = f.payload[14:13];
          if (fair_on && o == 1 && fair_seen < FAIR_PKTS) begin
            fair_cnt[src_in]++;
            fair_seen++;
          end
        end
      end
      for (int i = 0; i < NUM_IN; i++) begin
        check_val($sformatf("in_credit_o[%0d]", i), 32'(in_credit_o[i]), 32'(cred_exp[i]));
        if (in_credit_o[i]) begin
          check_val($sformatf("in_credit_vc_o[%0d]", i), 32'(in_credit_vc_o[i]),
                    32'(cred_vc[i]));
          vc_cred[i][in_credit_vc_o[i]]++;
          if (vc_cred[i][in_credit_vc_o[i]] > VC_DEPTH) begin
            note_failure($sformatf("input %0d returned more credits than flits", i));
          end
        end
      end
      // downstream frees slots after a random delay unless it stalls
      for (int o = 0; o < NUM_OUT; o++) begin
        ret_mask[o] = 1'b0;
        if (!withhold && pending[o] > 0 && ($random(seed) & 3) != 0) begin
          ret_mask[o] = 1'b1;
          pending[o]--;
        end
      end
    end
  end

  initial begin
    int  t_in;
    int  vc;
    int  rcyc;
    int  left [NUM_IN];
    bit  busy;
    in_valid_i = '0;
    in_vc_i    = '0;
    in_flit_i  = '0;
    rst_n_i    = 1'b0;
    for (int i = 0; i < NUM_IN; i++) begin
      fair_cnt[i]  = 0;
      pkts_left[i] = 0;
      left[i]      = FAIR_PKTS;
      for (int v = 0; v < NUM_VC; v++) begin
        vc_cred[i][v] = VC_DEPTH;
        rem[i][v]     = 0;
        dst[i][v]     = 0;
      end
    end
    for (int o = 0; o < NUM_OUT; o++) begin
      pending[o] = 0;
      owner[o]   = -1;
    end
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // idle router, nothing comes out and nothing is credited
    repeat (4) @(negedge clk_i);
    check_val("out_valid_o", 32'(out_valid_o), 32'h0);
    check_val("in_credit_o", 32'(in_credit_o), 32'h0);

    // single flit through an idle router
    @(posedge clk_i);
    send_flit(0, 0, 2, 1'b1);
    @(negedge clk_i);
    t_in = cycle;
    @(posedge clk_i);
    in_valid_i <= '0;
    @(negedge clk_i);
    while (!out_valid_o[2]) @(negedge clk_i);
    check_val("out_valid_o[2] latency", 32'(cycle - t_in), 32'd2);
    wait_drain();

    // both inputs load output 1 with single flit packets
    fair_on = 1'b1;
    while (left[0] > 0 || left[1] > 0) begin
      @(posedge clk_i);
      in_valid_i <= '0;
      for (int i = 0; i < NUM_IN; i++) begin
        pick_vc(i, 1'b0, vc);
        if (left[i] > 0 && vc >= 0) begin
          send_flit(i, vc, 1, 1'b1);
          left[i]--;
        end
      end
    end
    wait_drain();
    fair_on = 1'b0;
    for (int i = 0; i < NUM_IN; i++) begin
      if (fair_cnt[i] < 2) begin
        note_failure($sformatf("input %0d got too few turns on output 1", i));
      end
    end

    // random packets, downstream stalls in the middle of the run
    for (int i = 0; i < NUM_IN; i++) begin
      pkts_left[i] = RAND_PKTS;
    end
    rcyc = 0;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk_i);
      in_valid_i <= '0;
      withhold = (rcyc >= 100 && rcyc < 260);
      rcyc++;
      busy = 1'b0;
      for (int i = 0; i < NUM_IN; i++) begin
        random_step(i);
        if (pkts_left[i] > 0) busy = 1'b1;
        for (int v = 0; v < NUM_VC; v++) begin
          if (rem[i][v] > 0) busy = 1'b1;
        end
      end
    end
    withhold = 1'b0;
    wait_drain();

    $display("errors: %0d value, %0d other, flits sent %0d, received %0d",
             err_val, err_misc, tx_cnt, rx_cnt);
    if (err_val == 0 && err_misc == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
src/vcr_pkg.sv
src/sa_req_if.sv
src/vc_buffer.sv
src/sa_local.sv
src/switch_alloc_fsm.sv
src/credit_counter.sv
src/vc_router.sv
tb/tb_vc_router.sv

//--- Makefile
# Verilator build and run for the VC router slice

VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       := tb_vc_router
FILELIST  := sim.f
BUILD     := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

# the run passes only if the log holds the pass line
sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
